// File: design/sdram_ctrl_pkg.sv
package sdram_ctrl_pkg;

   // sdram geometry
   localparam int BA_W  = 2;
   localparam int ROW_W = 13;
   localparam int COL_W = 9;

   // word address drops the column low bit, one word is two beats
   localparam int ADR_W = BA_W + ROW_W + COL_W - 1;

   localparam int DATA_W = 32;
   localparam int DQ_W   = 16;
   localparam int BE_W   = DATA_W / 8;

   // timing in sdram_clk cycles
   localparam int T_RCD = 2;
   localparam int T_RP  = 2;

   // address bit that selects all banks or auto-precharge
   localparam int AP_BIT = 10;

   // {ras_n, cas_n, we_n}
   typedef enum logic [2:0] {
      CMD_LMR   = 3'b000,
      CMD_AREF  = 3'b001,
      CMD_PRE   = 3'b010,
      CMD_ACT   = 3'b011,
      CMD_WRITE = 3'b100,
      CMD_READ  = 3'b101,
      CMD_NOP   = 3'b111
   } sdram_cmd_e;

   typedef struct packed {
      sdram_cmd_e         cmd;
      logic [BA_W-1:0]    ba;
      logic [ROW_W-1:0]   a;
   } sdram_cmd_t;

   // queue head as presented by a request port
   typedef struct packed {
      logic               we;
      logic [ADR_W-1:0]   adr;
      logic [BE_W-1:0]    be;
      logic [DATA_W-1:0]  dat;
   } mem_req_t;

   typedef struct packed {
      logic               we;
      logic [BA_W-1:0]    ba;
      logic [ROW_W-1:0]   row;
      logic [COL_W-1:0]   col;
   } mem_loc_t;

endpackage

// File: design/port_arbiter.sv
module port_arbiter import sdram_ctrl_pkg::*; #(
   parameter int NR_PORTS = 3
) (
   input  logic                  sdram_clk,
   input  logic                  sdram_rst,
   input  logic [NR_PORTS-1:0]   req_empty_i,
   input  mem_req_t              req_i [NR_PORTS],
   input  logic                  idle_i,
   input  logic                  take_i,
   output logic                  grant_valid_o,
   output mem_loc_t              loc_o,
   output logic [DATA_W-1:0]     wdat_o,
   output logic [BE_W-1:0]       be_o,
   output logic [NR_PORTS-1:0]   grant_o,
   output logic [NR_PORTS-1:0]   req_re_o
);

   localparam int IDX_W = (NR_PORTS > 1) ? $clog2(NR_PORTS) : 1;

   logic [NR_PORTS-1:0] sel;
   logic [IDX_W-1:0]    sel_idx;
   mem_req_t            head;
   logic                load;

   // fixed priority, lowest index wins
   always_comb begin
      sel     = '0;
      sel_idx = '0;
      for (int p = NR_PORTS - 1; p >= 0; p--) begin
         if (!req_empty_i[p]) begin
            sel     = '0;
            sel[p]  = 1'b1;
            sel_idx = IDX_W'(p);
         end
      end
   end

   assign head = req_i[sel_idx];

   // grant is frozen once valid, until the fsm takes it
   assign load = idle_i && !grant_valid_o;

   always_ff @(posedge sdram_clk or posedge sdram_rst) begin
      if (sdram_rst) begin
         grant_valid_o <= 1'b0;
         grant_o       <= '0;
      end else if (take_i) begin
         grant_valid_o <= 1'b0;
      end else if (load) begin
         grant_valid_o <= |(~req_empty_i);
         grant_o       <= sel;
      end
   end

   // address split {ba, row, col[8:1]}, col bit 0 is always zero
   always_ff @(posedge sdram_clk) begin
      if (load) begin
         loc_o.we  <= head.we;
         loc_o.ba  <= head.adr[ADR_W-1 -: BA_W];
         loc_o.row <= head.adr[COL_W-1 +: ROW_W];
         loc_o.col <= {head.adr[COL_W-2:0], 1'b0};
         wdat_o    <= head.dat;
         be_o      <= head.be;
      end
   end

   // pop the granted queue
   assign req_re_o = take_i ? grant_o : '0;

   // a pop only ever hits a single port whose queue holds a request
   a_pop_valid: assert property (@(posedge sdram_clk) disable iff (sdram_rst)
      |req_re_o |-> $onehot(req_re_o) && grant_valid_o && !(|(req_re_o & req_empty_i)));

endmodule

// File: design/sdr_cmd_fsm.sv
module sdr_cmd_fsm import sdram_ctrl_pkg::*; #(
   parameter int CAS_LATENCY = 2,
   parameter int REF_PERIOD  = 200
) (
   input  logic         sdram_clk,
   input  logic         sdram_rst,
   input  logic         grant_valid_i,
   input  mem_loc_t     loc_i,
   output logic         idle_o,
   output logic         take_o,
   output logic         issue_read_o,
   output logic [1:0]   wr_beat_o,
   output sdram_cmd_t   cmd_o
);

   localparam int WAIT_W     = 5;
   localparam int INIT_WAIT  = 16;
   localparam int AREF_WAIT  = 8;
   localparam int REF_CNT_W  = $clog2(REF_PERIOD);

   // burst length 2, sequential, programmed burst on writes
   localparam logic [ROW_W-1:0] LMR_MODE = {6'b000000, 3'(CAS_LATENCY), 1'b0, 3'b001};

   typedef enum logic [3:0] {
      S_WAIT, S_PRE_ALL, S_AREF_1, S_AREF_2, S_LMR,
      S_IDLE, S_AREF, S_ACT, S_RW
   } state_e;

   state_e              state;
   state_e              after_wait;
   logic [WAIT_W-1:0]   wait_cnt;
   logic [REF_CNT_W-1:0] ref_cnt;
   logic                ref_pending;
   logic                wr_beat1;

   // refresh interval timer
   always_ff @(posedge sdram_clk or posedge sdram_rst) begin
      if (sdram_rst) begin
         ref_cnt     <= REF_CNT_W'(REF_PERIOD - 1);
         ref_pending <= 1'b0;
      end else begin
         if (ref_cnt == '0) begin
            ref_cnt     <= REF_CNT_W'(REF_PERIOD - 1);
            ref_pending <= 1'b1;
         end else begin
            ref_cnt <= ref_cnt - 1'b1;
            if (state == S_AREF) begin
               ref_pending <= 1'b0;
            end
         end
      end
   end

   // every command state hands its nop gap to S_WAIT
   always_ff @(posedge sdram_clk or posedge sdram_rst) begin
      if (sdram_rst) begin
         state      <= S_WAIT;
         after_wait <= S_PRE_ALL;
         wait_cnt   <= WAIT_W'(INIT_WAIT - 1);
         wr_beat1   <= 1'b0;
      end else begin
         wr_beat1 <= (state == S_RW) && loc_i.we;
         case (state)
            S_WAIT: begin
               if (wait_cnt == '0) begin
                  state <= after_wait;
               end else begin
                  wait_cnt <= wait_cnt - 1'b1;
               end
            end
            S_PRE_ALL: state <= S_AREF_1;
            S_AREF_1: begin
               state      <= S_WAIT;
               after_wait <= S_AREF_2;
               wait_cnt   <= WAIT_W'(AREF_WAIT - 1);
            end
            S_AREF_2: begin
               state      <= S_WAIT;
               after_wait <= S_LMR;
               wait_cnt   <= WAIT_W'(AREF_WAIT - 1);
            end
            S_LMR: state <= S_IDLE;
            S_IDLE: begin
               // refresh goes ahead of any grant
               if (ref_pending) begin
                  state <= S_AREF;
               end else if (grant_valid_i) begin
                  state <= S_ACT;
               end
            end
            S_AREF: begin
               state      <= S_WAIT;
               after_wait <= S_IDLE;
               wait_cnt   <= WAIT_W'(AREF_WAIT - 1);
            end
            S_ACT: begin
               state      <= S_WAIT;
               after_wait <= S_RW;
               wait_cnt   <= WAIT_W'(T_RCD - 1);
            end
            S_RW: begin
               state      <= S_WAIT;
               after_wait <= S_IDLE;
               wait_cnt   <= WAIT_W'(T_RP + 1);
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   assign idle_o       = (state == S_IDLE);
   assign take_o       = (state == S_RW);
   assign issue_read_o = take_o && !loc_i.we;
   assign wr_beat_o    = {wr_beat1, take_o && loc_i.we};

   always_comb begin
      cmd_o = '{cmd: CMD_NOP, ba: '0, a: '0};
      case (state)
         S_PRE_ALL: begin
            cmd_o.cmd       = CMD_PRE;
            cmd_o.a[AP_BIT] = 1'b1;
         end
         S_AREF_1, S_AREF_2, S_AREF: cmd_o.cmd = CMD_AREF;
         S_LMR: begin
            cmd_o.cmd = CMD_LMR;
            cmd_o.a   = LMR_MODE;
         end
         S_ACT: begin
            cmd_o.cmd = CMD_ACT;
            cmd_o.ba  = loc_i.ba;
            cmd_o.a   = loc_i.row;
         end
         S_RW: begin
            cmd_o.cmd          = loc_i.we ? CMD_WRITE : CMD_READ;
            cmd_o.ba           = loc_i.ba;
            cmd_o.a[COL_W-1:0] = loc_i.col;
            // auto-precharge
            cmd_o.a[AP_BIT]    = 1'b1;
         end
         default: ;
      endcase
   end

   a_no_act_on_ref: assert property (@(posedge sdram_clk) disable iff (sdram_rst)
      (idle_o && ref_pending) |=> (cmd_o.cmd != CMD_ACT));

   a_rw_after_act: assert property (@(posedge sdram_clk) disable iff (sdram_rst)
      (cmd_o.cmd inside {CMD_READ, CMD_WRITE}) |->
         ($past(cmd_o.cmd, T_RCD + 1) == CMD_ACT) && ($past(cmd_o.ba, T_RCD + 1) == cmd_o.ba));

endmodule

// File: design/write_data_path.sv
module write_data_path import sdram_ctrl_pkg::*; (
   input  logic                  sdram_clk,
   input  logic                  sdram_rst,
   input  logic [1:0]            wr_beat_i,
   input  logic [DATA_W-1:0]     wdat_i,
   input  logic [BE_W-1:0]       be_i,
   output logic [DQ_W-1:0]       dq_o,
   output logic [DQ_W/8-1:0]     dqm_o,
   output logic                  dq_oe_o
);

   logic [DQ_W-1:0]   dat_lo_q;
   logic [DQ_W/8-1:0] dqm_lo_q;

   // low half-word waits one cycle for beat 1
   always_ff @(posedge sdram_clk) begin
      if (wr_beat_i[0]) begin
         dat_lo_q <= wdat_i[DQ_W-1:0];
      end
   end

   always_ff @(posedge sdram_clk or posedge sdram_rst) begin
      if (sdram_rst) begin
         dqm_lo_q <= '0;
      end else if (wr_beat_i[0]) begin
         dqm_lo_q <= ~be_i[DQ_W/8-1:0];
      end
   end

   // beat 0 is the high half-word
   assign dq_o    = wr_beat_i[0] ? wdat_i[DATA_W-1 -: DQ_W] : dat_lo_q;
   assign dq_oe_o = |wr_beat_i;

   // dqm stays 00 outside write beats, reads need every byte
   always_comb begin
      dqm_o = '0;
      if (wr_beat_i[0]) begin
         dqm_o = ~be_i[BE_W-1 -: DQ_W/8];
      end else if (wr_beat_i[1]) begin
         dqm_o = dqm_lo_q;
      end
   end

endmodule

// File: design/read_capture.sv
module read_capture import sdram_ctrl_pkg::*; #(
   parameter int NR_PORTS    = 3,
   parameter int CAS_LATENCY = 2
) (
   input  logic                  sdram_clk,
   input  logic                  sdram_rst,
   input  logic                  issue_read_i,
   input  logic [NR_PORTS-1:0]   grant_i,
   input  logic [DQ_W-1:0]       dq_i,
   output logic                  rd_valid_o,
   output logic [DATA_W-1:0]     rd_data_o,
   output logic [NR_PORTS-1:0]   rd_port_o
);

   // cas latency plus two beats
   localparam int DEPTH = CAS_LATENCY + 2;

   typedef struct packed {
      logic                vld;
      logic [NR_PORTS-1:0] port;
   } rd_tag_t;

   rd_tag_t         tag_line [DEPTH];
   logic [DQ_W-1:0] dq_d1;
   logic [DQ_W-1:0] dq_d2;

   // one slot per cycle, so back to back reads stay in order
   always_ff @(posedge sdram_clk or posedge sdram_rst) begin
      if (sdram_rst) begin
         for (int i = 0; i < DEPTH; i++) begin
            tag_line[i] <= '0;
         end
      end else begin
         tag_line[0] <= '{vld: issue_read_i, port: grant_i};
         for (int i = 1; i < DEPTH; i++) begin
            tag_line[i] <= tag_line[i-1];
         end
      end
   end

   always_ff @(posedge sdram_clk) begin
      dq_d1 <= dq_i;
      dq_d2 <= dq_d1;
   end

   // first beat lands in the upper half
   assign rd_data_o  = {dq_d2, dq_d1};
   assign rd_valid_o = tag_line[DEPTH-1].vld;
   assign rd_port_o  = tag_line[DEPTH-1].port;

   a_rd_tag: assert property (@(posedge sdram_clk) disable iff (sdram_rst)
      rd_valid_o |-> $onehot(rd_port_o));

endmodule

// File: design/sdram_ctrl_top.sv
module sdram_ctrl_top import sdram_ctrl_pkg::*; #(
   parameter int NR_PORTS    = 3,
   parameter int CAS_LATENCY = 2,
   parameter int REF_PERIOD  = 200
) (
   input  logic                  sdram_clk,
   input  logic                  sdram_rst,
   input  logic [NR_PORTS-1:0]   req_empty_i,
   input  mem_req_t              req_i [NR_PORTS],
   output logic [NR_PORTS-1:0]   req_re_o,
   output logic                  rd_valid_o,
   output logic [DATA_W-1:0]     rd_data_o,
   output logic [NR_PORTS-1:0]   rd_port_o,
   output sdram_cmd_t            cmd_o,
   output logic [DQ_W-1:0]       dq_o,
   output logic [DQ_W/8-1:0]     dqm_o,
   output logic                  dq_oe_o,
   input  logic [DQ_W-1:0]       dq_i
);

   logic                idle;
   logic                take;
   logic                grant_valid;
   logic                issue_read;
   logic [1:0]          wr_beat;
   mem_loc_t            loc;
   logic [DATA_W-1:0]   wdat;
   logic [BE_W-1:0]     be;
   logic [NR_PORTS-1:0] grant;

   port_arbiter #(.NR_PORTS(NR_PORTS)) u_arbiter (
      .sdram_clk, .sdram_rst, .req_empty_i, .req_i,
      .idle_i(idle), .take_i(take), .grant_valid_o(grant_valid),
      .loc_o(loc), .wdat_o(wdat), .be_o(be), .grant_o(grant), .req_re_o
   );

   sdr_cmd_fsm #(.CAS_LATENCY(CAS_LATENCY), .REF_PERIOD(REF_PERIOD)) u_fsm (
      .sdram_clk, .sdram_rst, .grant_valid_i(grant_valid), .loc_i(loc),
      .idle_o(idle), .take_o(take), .issue_read_o(issue_read),
      .wr_beat_o(wr_beat), .cmd_o
   );

   write_data_path u_wdp (
      .sdram_clk, .sdram_rst, .wr_beat_i(wr_beat), .wdat_i(wdat), .be_i(be),
      .dq_o, .dqm_o, .dq_oe_o
   );

   read_capture #(.NR_PORTS(NR_PORTS), .CAS_LATENCY(CAS_LATENCY)) u_rdc (
      .sdram_clk, .sdram_rst, .issue_read_i(issue_read), .grant_i(grant),
      .dq_i, .rd_valid_o, .rd_data_o, .rd_port_o
   );

endmodule

// File: testbench/tb_clock_gen.sv
module tb_clock_gen #(
   parameter int PERIOD     = 4,
   parameter int RST_CYCLES = 2
) (
   output logic sdram_clk,
   output logic sdram_rst
);
   timeunit 1ns;
   timeprecision 100ps;

   initial begin
      sdram_clk = 1'b0;
      forever #(PERIOD / 2) sdram_clk = ~sdram_clk;
   end

   // reset is released on a rising edge
   initial begin
      sdram_rst = 1'b1;
      repeat (RST_CYCLES) @(posedge sdram_clk);
      sdram_rst <= 1'b0;
   end

endmodule

// File: testbench/tb_sdr_model.sv
module tb_sdr_model import sdram_ctrl_pkg::*; #(
   parameter int CL = 2
) (
   input  logic              sdram_clk,
   input  sdram_cmd_t        cmd_i,
   input  logic [DQ_W-1:0]   dq_i,
   input  logic [DQ_W/8-1:0] dqm_i,
   output logic [DQ_W-1:0]   dq_o
);
   timeunit 1ns;
   timeprecision 100ps;

   localparam int WA_W = BA_W + ROW_W + COL_W;

   logic [DQ_W-1:0]  mem [logic [WA_W-1:0]];
   logic [ROW_W-1:0] open_row [2**BA_W];
   logic [DQ_W-1:0]  rd_line [CL];
   logic             wr_next;
   logic [WA_W-1:0]  wr_next_adr;

   // words never written read back a pattern of their full address
   function automatic logic [DQ_W-1:0] fetch(input logic [WA_W-1:0] wa);
      if (mem.exists(wa)) begin
         return mem[wa];
      end
      return wa[DQ_W-1:0] ^ {wa[WA_W-1 -: 8], wa[WA_W-1 -: 8]};
   endfunction

   // dqm high masks the byte
   task automatic store(input logic [WA_W-1:0] wa, input logic [DQ_W-1:0] d,
                        input logic [DQ_W/8-1:0] m);
      logic [DQ_W-1:0] w;
      w = fetch(wa);
      for (int b = 0; b < DQ_W / 8; b++) begin
         if (!m[b]) begin
            w[8*b +: 8] = d[8*b +: 8];
         end
      end
      mem[wa] = w;
   endtask

   initial begin
      dq_o    = '0;
      wr_next = 1'b0;
      for (int i = 0; i < CL; i++) begin
         rd_line[i] = '0;
      end
   end

   always @(posedge sdram_clk) begin : cmd_decode
      logic [WA_W-1:0] wa;
      wa = {cmd_i.ba, open_row[cmd_i.ba], cmd_i.a[COL_W-1:0]};
      // beat 0 reaches dq CL cycles after READ
      dq_o <= rd_line[0];
      for (int i = 0; i < CL - 1; i++) begin
         rd_line[i] <= rd_line[i+1];
      end
      rd_line[CL-1] <= '0;
      if (wr_next) begin
         store(wr_next_adr, dq_i, dqm_i);
      end
      wr_next <= 1'b0;
      case (cmd_i.cmd)
         CMD_ACT: open_row[cmd_i.ba] <= cmd_i.a;
         CMD_WRITE: begin
            store(wa, dq_i, dqm_i);
            wr_next     <= 1'b1;
            wr_next_adr <= wa | WA_W'(1);
         end
         CMD_READ: begin
            rd_line[CL-2] <= fetch(wa);
            rd_line[CL-1] <= fetch(wa | WA_W'(1));
         end
         default: ;
      endcase
   end

endmodule

// File: testbench/tb_sdram_ctrl.sv
module tb_sdram_ctrl import sdram_ctrl_pkg::*; ();
   timeunit 1ns;
   timeprecision 100ps;

   localparam int NR_PORTS   = 3;
   localparam int CL         = 2;
   localparam int REF_PERIOD = 200;
   localparam int N_ADDR     = 6;
   localparam int N_EDGE     = 3;
   // write, write, read per address, two reads per port, write and read per edge address
   localparam int NR_REQS    = 3 * N_ADDR + 2 * NR_PORTS + 2 * N_EDGE;

   typedef struct packed {
      logic [NR_PORTS-1:0] port;
      logic [DATA_W-1:0]   data;
   } rd_exp_t;

   logic                sdram_clk;
   logic                sdram_rst;
   logic [NR_PORTS-1:0] req_empty_i;
   mem_req_t            req [NR_PORTS];
   logic [NR_PORTS-1:0] req_re_o;
   logic                rd_valid_o;
   logic [DATA_W-1:0]   rd_data_o;
   logic [NR_PORTS-1:0] rd_port_o;
   sdram_cmd_t          cmd_o;
   logic [DQ_W-1:0]     dq_o;
   logic [DQ_W/8-1:0]   dqm_o;
   logic                dq_oe_o;
   logic [DQ_W-1:0]     dq_i;

   mem_req_t            port_q [NR_PORTS][$];
   logic [DATA_W-1:0]   ref_mem [logic [ADR_W-1:0]];
   rd_exp_t             exp_q [$];
   int                  pop_log [$];
   logic [ADR_W-1:0]    adr_list [N_ADDR];
   logic [31:0]         lfsr = 32'h3a240470;
   int                  err_cnt = 0;
   int                  err_mark = 0;
   int                  tests_run = 0;
   int                  nn_cnt;
   int                  since_aref;
   int                  aref_cnt;
   mem_req_t            cur;
   logic [BA_W+ROW_W+COL_W-1:0] cur_loc;

   tb_clock_gen #(.PERIOD(4), .RST_CYCLES(2)) u_clk (.sdram_clk, .sdram_rst);

   sdram_ctrl_top #(.NR_PORTS(NR_PORTS), .CAS_LATENCY(CL), .REF_PERIOD(REF_PERIOD)) DUT (
      .sdram_clk, .sdram_rst, .req_empty_i, .req_i(req), .req_re_o,
      .rd_valid_o, .rd_data_o, .rd_port_o, .cmd_o, .dq_o, .dqm_o, .dq_oe_o, .dq_i
   );

   tb_sdr_model #(.CL(CL)) u_mem (
      .sdram_clk, .cmd_i(cmd_o), .dq_i(dq_o), .dqm_i(dqm_o), .dq_o(dq_i)
   );

   task automatic report_mismatch(input string msg);
      $display("FAIL %0t ns: %s", $time, msg);
      err_cnt++;
   endtask

   // fibonacci lfsr with taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic draw(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         v    = {v[30:0], lfsr[0]};
      end
   endtask

   task automatic push_req(input int p, input logic we, input logic [ADR_W-1:0] adr,
                           input logic [BE_W-1:0] be, input logic [DATA_W-1:0] dat);
      mem_req_t r;
      r = {we, adr, be, dat};
      port_q[p].push_back(r);
   endtask

   // reference memory follows the pop order and byte enables merge into the old word
   task automatic serve_pop(input int p);
      mem_req_t          r;
      logic [DATA_W-1:0] w;
      pop_log.push_back(p);
      if (port_q[p].size() == 0) begin
         $display("port %0d was popped at %0t ns while its queue was empty", p, $time);
         err_cnt++;
         return;
      end
      r = port_q[p].pop_front();
      w = ref_mem.exists(r.adr) ? ref_mem[r.adr] : '0;
      if (r.we) begin
         for (int b = 0; b < BE_W; b++) begin
            if (r.be[b]) begin
               w[8*b +: 8] = r.dat[8*b +: 8];
            end
         end
         ref_mem[r.adr] = w;
      end else begin
         exp_q.push_back({NR_PORTS'(1) << p, w});
      end
   endtask

   function automatic bit work_left();
      for (int p = 0; p < NR_PORTS; p++) begin
         if (port_q[p].size() != 0) begin
            return 1'b1;
         end
      end
      return exp_q.size() != 0;
   endfunction

   task automatic wait_drain();
      do @(negedge sdram_clk); while (work_left());
   endtask

   task automatic end_test(input string name);
      $display("test %0s: %0s", name, (err_cnt == err_mark) ? "ok" : "errors");
      err_mark = err_cnt;
      tests_run++;
   endtask

   initial begin
      req_empty_i = '1;
      for (int p = 0; p < NR_PORTS; p++) begin
         req[p] = '0;
      end
   end

   // a popped queue head is replaced after the pop edge
   always @(posedge sdram_clk) begin
      for (int p = 0; p < NR_PORTS; p++) begin
         if (req_re_o[p]) begin
            serve_pop(p);
         end
         req_empty_i[p] <= (port_q[p].size() == 0);
         req[p]         <= (port_q[p].size() == 0) ? '0 : port_q[p][0];
      end
   end

   always_comb begin
      cur = '0;
      for (int p = 0; p < NR_PORTS; p++) begin
         if (req_re_o[p]) begin
            cur = req[p];
         end
      end
   end
   assign cur_loc = {cur.adr, 1'b0};

   always_ff @(posedge sdram_clk or posedge sdram_rst) begin
      if (sdram_rst) begin
         nn_cnt     <= 0;
         since_aref <= 0;
         aref_cnt   <= 0;
      end else begin
         if (cmd_o.cmd != CMD_NOP && nn_cnt < 4) begin
            nn_cnt <= nn_cnt + 1;
         end
         if (cmd_o.cmd == CMD_AREF) begin
            since_aref <= 0;
            aref_cnt   <= aref_cnt + 1;
         end else begin
            since_aref <= since_aref + 1;
         end
      end
   end

   always @(posedge sdram_clk) begin : check_reads
      rd_exp_t e;
      if (!sdram_rst && rd_valid_o) begin
         if (exp_q.size() == 0) begin
            $display("read result at %0t ns arrived with no read outstanding", $time);
            err_cnt++;
         end else begin
            e = exp_q.pop_front();
            a_rd_port: assert (rd_port_o == e.port)
               else report_mismatch($sformatf("rd_port_o %b, expected %b", rd_port_o, e.port));
            a_rd_data: assert (rd_data_o == e.data)
               else report_mismatch($sformatf("rd_data_o %h, expected %h", rd_data_o, e.data));
         end
      end
   end

   a_reset_quiet: assert property (@(posedge sdram_clk) $fell(sdram_rst) |->
      cmd_o.cmd == CMD_NOP && req_re_o == '0 && !rd_valid_o && !dq_oe_o)
      else report_mismatch("control output active after reset");

   a_init_pre: assert property (@(posedge sdram_clk) disable iff (sdram_rst)
      (cmd_o.cmd != CMD_NOP && nn_cnt == 0) |-> cmd_o.cmd == CMD_PRE && cmd_o.a[AP_BIT])
      else report_mismatch("first init command is not PRE all");

   a_init_aref: assert property (@(posedge sdram_clk) disable iff (sdram_rst)
      (cmd_o.cmd != CMD_NOP && nn_cnt inside {1, 2}) |-> cmd_o.cmd == CMD_AREF)
      else report_mismatch("init commands two and three are not AREF");

   a_init_lmr: assert property (@(posedge sdram_clk) disable iff (sdram_rst)
      (cmd_o.cmd != CMD_NOP && nn_cnt == 3) |->
         cmd_o.cmd == CMD_LMR && cmd_o.a[6:4] == 3'(CL) && cmd_o.a[3:0] == 4'b0001)
      else report_mismatch("fourth init command is not LMR with the expected mode");

   a_refresh_window: assert property (@(posedge sdram_clk) disable iff (sdram_rst)
      (nn_cnt == 4) |-> since_aref < REF_PERIOD + 20)
      else report_mismatch("no AREF within the refresh window");

   // address split {ba, row, col} with col bit 0 zero
   a_rw_addr: assert property (@(posedge sdram_clk) disable iff (sdram_rst)
      (cmd_o.cmd inside {CMD_READ, CMD_WRITE}) |-> $onehot(req_re_o)
         && cmd_o.cmd == (cur.we ? CMD_WRITE : CMD_READ)
         && cmd_o.ba == cur_loc[COL_W+ROW_W +: BA_W]
         && cmd_o.a[COL_W-1:0] == cur_loc[COL_W-1:0] && cmd_o.a[AP_BIT]
         && $past(cmd_o.cmd, T_RCD + 1) == CMD_ACT && $past(cmd_o.ba, T_RCD + 1) == cmd_o.ba
         && $past(cmd_o.a, T_RCD + 1) == cur_loc[COL_W +: ROW_W])
      else report_mismatch("READ/WRITE or its ACT carries a wrong address");

   a_wr_oe: assert property (@(posedge sdram_clk) disable iff (sdram_rst)
      cmd_o.cmd == CMD_WRITE |-> dq_oe_o ##1 dq_oe_o ##1 !dq_oe_o)
      else report_mismatch("dq_oe_o is not high for exactly two write beats");

   a_dqm_idle: assert property (@(posedge sdram_clk) disable iff (sdram_rst)
      !dq_oe_o |-> dqm_o == '0)
      else report_mismatch("dqm_o not 00 outside write beats");

   a_rd_latency: assert property (@(posedge sdram_clk) disable iff (sdram_rst)
      rd_valid_o |-> $past(cmd_o.cmd, CL + 2) == CMD_READ)
      else report_mismatch("rd_valid_o not CL+2 cycles after READ");

   initial begin : stimulus
      logic [31:0] adr;
      logic [31:0] d0;
      logic [31:0] d1;
      logic [31:0] be;
      int          aref_mark;

      while (nn_cnt < 4) @(negedge sdram_clk);
      end_test("init_sequence");

      // full write, partial write and read back per address
      @(negedge sdram_clk);
      for (int i = 0; i < N_ADDR; i++) begin
         draw(ADR_W, adr);
         draw(DATA_W, d0);
         draw(DATA_W, d1);
         draw(BE_W, be);
         adr_list[i] = adr[ADR_W-1:0];
         push_req(i % NR_PORTS, 1'b1, adr_list[i], 4'hf, d0);
         push_req(i % NR_PORTS, 1'b1, adr_list[i], be[BE_W-1:0], d1);
         push_req(i % NR_PORTS, 1'b0, adr_list[i], '0, '0);
      end
      wait_drain();
      end_test("write_read_merge");

      // every port non-empty at once
      @(negedge sdram_clk);
      pop_log.delete();
      for (int p = 0; p < NR_PORTS; p++) begin
         push_req(p, 1'b0, adr_list[2*p], '0, '0);
         push_req(p, 1'b0, adr_list[2*p+1], '0, '0);
      end
      wait_drain();
      for (int i = 0; i < pop_log.size(); i++) begin
         a_pop_order: assert (pop_log[i] == i / 2)
            else report_mismatch($sformatf("pop %0d served port %0d, expected port %0d",
                                           i, pop_log[i], i / 2));
      end
      end_test("port_priority");

      aref_mark = aref_cnt;
      while (aref_cnt < aref_mark + 3) @(negedge sdram_clk);
      end_test("refresh_interval");

      // address extremes for the bank, row and column split
      @(negedge sdram_clk);
      for (int i = 0; i < N_EDGE; i++) begin
         draw(DATA_W, d0);
         adr = (i == 0) ? 32'h7fffff : (i == 1) ? 32'h0 : 32'h555555;
         push_req(NR_PORTS - 1, 1'b1, adr[ADR_W-1:0], 4'hf, d0);
         push_req(NR_PORTS - 1, 1'b0, adr[ADR_W-1:0], '0, '0);
      end
      wait_drain();
      end_test("address_split");

      $display("%0d tests run, %0d checks failed", tests_run, err_cnt);
      if (err_cnt == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

   initial begin : watchdog
      #(40 * NR_REQS * REF_PERIOD);
      $display("timeout after %0d ns, the tests did not finish", 40 * NR_REQS * REF_PERIOD);
      $display("Simulation FAILED");
      $finish;
   end

endmodule

// File: vlog.f
design/sdram_ctrl_pkg.sv
design/port_arbiter.sv
design/sdr_cmd_fsm.sv
design/write_data_path.sv
design/read_capture.sv
design/sdram_ctrl_top.sv
testbench/tb_clock_gen.sv
testbench/tb_sdr_model.sv
testbench/tb_sdram_ctrl.sv

// File: Bender.yml
package:
  name: sdram_ctrl

sources:
  - design/sdram_ctrl_pkg.sv
  - design/port_arbiter.sv
  - design/sdr_cmd_fsm.sv
  - design/write_data_path.sv
  - design/read_capture.sv
  - design/sdram_ctrl_top.sv
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/tb_sdr_model.sv
      - testbench/tb_sdram_ctrl.sv
